//--- src/sdram_map_pkg.sv
// SDRAM layout shared by the ROM loader and the slot arbiter, imported where needed
package sdram_map_pkg;

    // SDRAM side
    typedef logic [21:0] sdram_addr_t;
    typedef logic [1:0]  bank_t;
    // Active low, bit 1 guards the high byte
    typedef logic [1:0]  wrmask_t;

    // Data widths
    typedef logic [15:0] word_t;
    typedef logic [31:0] dword_t;
    typedef logic [7:0]  byte_t;

    // Loader byte address
    typedef logic [24:0] ioctl_addr_t;

    // Region offsets inside their banks
    localparam sdram_addr_t SOUND_OFFSET = 22'h00_0000;
    localparam sdram_addr_t RAM_OFFSET   = 22'h20_0000;
    localparam sdram_addr_t VRAM_OFFSET  = 22'h30_0000;
    localparam sdram_addr_t GFX_OFFSET   = 22'h00_0000;
    localparam sdram_addr_t CPU_OFFSET   = 22'h00_0000;

    // Bank numbers
    localparam bank_t BANK_SND = 2'd0;
    localparam bank_t BANK_CPU = 2'd1;
    localparam bank_t BANK_GFX = 2'd2;

    // Download file layout, CPU code first, then sound, then graphics
    localparam ioctl_addr_t LOAD_SND_START = 25'h040_0000;
    localparam ioctl_addr_t LOAD_GFX_START = 25'h041_0000;

endpackage

//--- src/slot_pkg.sv
// Slot identities and request FSM states for the SDRAM slot multiplexer
package slot_pkg;

    // Listed in priority order, highest first
    typedef enum logic [2:0] {
        SLOT_OBJ = 3'd0,
        SLOT_SCR = 3'd1,
        SLOT_ROM = 3'd2,
        SLOT_RAM = 3'd3,
        SLOT_SND = 3'd4
    } slot_id_t;

    localparam int SLOT_COUNT = 5;

    // Bit index matches the slot_id_t value
    typedef logic [SLOT_COUNT-1:0] slot_vec_t;

    // Client address widths
    typedef logic [20:0] rom_addr_t;
    typedef logic [16:0] ram_addr_t;
    // Graphics address before the final zero bit is appended
    typedef logic [20:0] gfx_addr_t;
    typedef logic [15:0] snd_addr_t;

    // One SDRAM access at a time
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_ACK  = 2'd1,
        WAIT_DATA = 2'd2,
        DONE      = 2'd3
    } req_state_t;

endpackage

//--- src/rom_loader.sv
// ROM download path, maps loader byte writes to SDRAM programming writes
`timescale 1ns/100ps

module rom_loader import sdram_map_pkg::*; (
    input  logic        VB,
    input  logic        rst_n,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output wrmask_t     prog_mask,
    output bank_t       prog_bank,
    output logic        prog_we
);

    ioctl_addr_t rel_addr;
    sdram_addr_t base_addr;
    sdram_addr_t nxt_addr;
    bank_t       nxt_bank;
    logic        accept;

    // Region decode
    always_comb begin
        if (ioctl_addr < LOAD_SND_START) begin
            rel_addr  = ioctl_addr;
            base_addr = CPU_OFFSET;
            nxt_bank  = BANK_CPU;
        end else if (ioctl_addr < LOAD_GFX_START) begin
            rel_addr  = ioctl_addr - LOAD_SND_START;
            base_addr = SOUND_OFFSET;
            nxt_bank  = BANK_SND;
        end else begin
            rel_addr  = ioctl_addr - LOAD_GFX_START;
            base_addr = GFX_OFFSET;
            nxt_bank  = BANK_GFX;
        end
        // Byte offset to word offset
        nxt_addr = base_addr + rel_addr[22:1];
    end

    // A new byte waits until the previous write has been acknowledged
    assign accept = ioctl_wr && downloading && !prog_we;

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (accept) begin
            prog_we <= 1'b1;
        end else if (prog_we && sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

    // Write payload
    always_ff @(posedge VB) begin
        if (accept) begin
            prog_addr <= nxt_addr;
            prog_bank <= nxt_bank;
            prog_data <= ioctl_data;
            // Even bytes land in the low half of the word
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

endmodule

//--- src/slot_arbiter.sv
// Fixed-priority arbiter that turns the winning client request into an SDRAM command
`timescale 1ns/100ps

module slot_arbiter import sdram_map_pkg::*, slot_pkg::*; (
    input  logic        VB,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        busy,
    input  logic        rom_cs,
    input  rom_addr_t   rom_addr,
    input  logic        ram_cs,
    input  logic        ram_vram_sel,
    input  ram_addr_t   ram_addr,
    input  logic        ram_rnw,
    input  word_t       ram_din,
    input  wrmask_t     ram_dsn,
    input  logic        obj_cs,
    input  gfx_addr_t   obj_addr,
    input  logic        scr_cs,
    input  gfx_addr_t   scr_addr,
    input  logic        snd_cs,
    input  snd_addr_t   snd_addr,
    output logic        cmd_valid,
    output slot_id_t    cmd_slot,
    output sdram_addr_t cmd_addr,
    output bank_t       cmd_bank,
    output logic        cmd_rnw,
    output wrmask_t     cmd_wrmask,
    output word_t       cmd_data,
    output logic        cmd_byte_hi,
    output logic        refresh_en
);

    slot_vec_t   req;
    logic        grant;
    slot_id_t    nxt_slot;
    sdram_addr_t nxt_addr;
    bank_t       nxt_bank;
    logic        nxt_rnw;
    wrmask_t     nxt_wrmask;

    assign req[SLOT_OBJ] = obj_cs;
    assign req[SLOT_SCR] = scr_cs;
    assign req[SLOT_ROM] = rom_cs;
    assign req[SLOT_RAM] = ram_cs;
    assign req[SLOT_SND] = snd_cs;

    // Free only when nothing is queued or in flight
    assign grant = |req && !busy && !downloading && !cmd_valid;

    // Controller may refresh when nobody needs the bus
    assign refresh_en = !(|req) && !busy && !downloading;

    // Winner selection, highest priority checked first
    always_comb begin
        nxt_rnw    = 1'b1;
        nxt_wrmask = 2'b11;
        if (req[SLOT_OBJ]) begin
            nxt_slot = SLOT_OBJ;
            nxt_addr = GFX_OFFSET + {obj_addr, 1'b0};
            nxt_bank = BANK_GFX;
        end else if (req[SLOT_SCR]) begin
            nxt_slot = SLOT_SCR;
            nxt_addr = GFX_OFFSET + {scr_addr, 1'b0};
            nxt_bank = BANK_GFX;
        end else if (req[SLOT_ROM]) begin
            nxt_slot = SLOT_ROM;
            nxt_addr = CPU_OFFSET + {1'b0, rom_addr};
            nxt_bank = BANK_CPU;
        end else if (req[SLOT_RAM]) begin
            nxt_slot   = SLOT_RAM;
            nxt_addr   = (ram_vram_sel ? VRAM_OFFSET : RAM_OFFSET) + {5'd0, ram_addr};
            // Work RAM and VRAM share bank 0 with the sound ROM
            nxt_bank   = BANK_SND;
            nxt_rnw    = ram_rnw;
            nxt_wrmask = ram_dsn;
        end else begin
            nxt_slot = SLOT_SND;
            nxt_addr = SOUND_OFFSET + {7'd0, snd_addr[15:1]};
            nxt_bank = BANK_SND;
        end
    end

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= grant;
        end
    end

    // Command fields
    always_ff @(posedge VB) begin
        if (grant) begin
            cmd_slot    <= nxt_slot;
            cmd_addr    <= nxt_addr;
            cmd_bank    <= nxt_bank;
            cmd_rnw     <= nxt_rnw;
            cmd_wrmask  <= nxt_wrmask;
            cmd_data    <= ram_din;
            cmd_byte_hi <= snd_addr[0];
        end
    end

endmodule

//--- src/sdram_request.sv
// Runs one SDRAM access at a time and hands data and ok back to the granted slot
`timescale 1ns/100ps

module sdram_request import sdram_map_pkg::*, slot_pkg::*; (
    input  logic        VB,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  slot_id_t    cmd_slot,
    input  sdram_addr_t cmd_addr,
    input  bank_t       cmd_bank,
    input  logic        cmd_rnw,
    input  wrmask_t     cmd_wrmask,
    input  word_t       cmd_data,
    input  logic        cmd_byte_hi,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  dword_t      data_read,
    output logic        busy,
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    output bank_t       sdram_bank,
    output logic        sdram_rnw,
    output wrmask_t     sdram_wrmask,
    output word_t       data_write,
    output slot_vec_t   slot_ok,
    output dword_t      rd_data,
    output byte_t       snd_data
);

    req_state_t state;
    slot_id_t   slot_q;
    logic       byte_hi_q;

    // Covers the command cycle too, so the arbiter never queues a second one
    assign busy = cmd_valid || (state != IDLE);

    always_ff @(posedge VB) begin
        if (!rst_n) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            slot_ok   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    slot_ok <= '0;
                    if (cmd_valid) begin
                        sdram_req <= 1'b1;
                        state     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    // Writes end with data_rdy as well
                    if (data_rdy) begin
                        slot_ok <= slot_vec_t'(1) << slot_q;
                        state   <= DONE;
                    end
                end
                DONE: begin
                    slot_ok <= '0;
                    state   <= IDLE;
                end
                default: begin
                    sdram_req <= 1'b0;
                    slot_ok   <= '0;
                    state     <= IDLE;
                end
            endcase
        end
    end

    // Command latch, held on the SDRAM port for the whole access
    always_ff @(posedge VB) begin
        if (state == IDLE && cmd_valid) begin
            slot_q       <= cmd_slot;
            byte_hi_q    <= cmd_byte_hi;
            sdram_addr   <= cmd_addr;
            sdram_bank   <= cmd_bank;
            sdram_rnw    <= cmd_rnw;
            sdram_wrmask <= cmd_wrmask;
            data_write   <= cmd_data;
        end
    end

    // Read data, valid together with the ok pulse
    always_ff @(posedge VB) begin
        if (state == WAIT_DATA && data_rdy) begin
            rd_data  <= data_read;
            // Sound ROM is byte wide, odd bytes sit in the upper lane
            snd_data <= byte_hi_q ? data_read[15:8] : data_read[7:0];
        end
    end

endmodule

//--- src/cps_sdram_top.sv
// Memory side top level, ties the ROM loader and the SDRAM slot mux to one port
`timescale 1ns/100ps

module cps_sdram_top import sdram_map_pkg::*, slot_pkg::*; (
    input  logic        VB,
    input  logic        rst_n,
    // ROM download
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_data,
    input  logic        ioctl_wr,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output wrmask_t     prog_mask,
    output bank_t       prog_bank,
    output logic        prog_we,
    // Main CPU ROM
    input  logic        rom_cs,
    input  rom_addr_t   rom_addr,
    output logic        rom_ok,
    output word_t       rom_data,
    // Main CPU RAM and VRAM
    input  logic        ram_cs,
    input  logic        ram_vram_sel,
    input  ram_addr_t   ram_addr,
    input  logic        ram_rnw,
    input  word_t       ram_din,
    input  wrmask_t     ram_dsn,
    output logic        ram_ok,
    output word_t       ram_data,
    // Graphics ROM
    input  logic        obj_cs,
    input  gfx_addr_t   obj_addr,
    output logic        obj_ok,
    output dword_t      obj_data,
    input  logic        scr_cs,
    input  gfx_addr_t   scr_addr,
    output logic        scr_ok,
    output dword_t      scr_data,
    // Sound CPU ROM
    input  logic        snd_cs,
    input  snd_addr_t   snd_addr,
    output logic        snd_ok,
    output byte_t       snd_data,
    // SDRAM controller
    output logic        sdram_req,
    input  logic        sdram_ack,
    output sdram_addr_t sdram_addr,
    output bank_t       sdram_bank,
    output logic        sdram_rnw,
    output wrmask_t     sdram_wrmask,
    output word_t       data_write,
    input  logic        data_rdy,
    input  dword_t      data_read,
    output logic        refresh_en
);

    logic        busy;
    logic        cmd_valid;
    slot_id_t    cmd_slot;
    sdram_addr_t cmd_addr;
    bank_t       cmd_bank;
    logic        cmd_rnw;
    wrmask_t     cmd_wrmask;
    word_t       cmd_data;
    logic        cmd_byte_hi;
    slot_vec_t   slot_ok;
    dword_t      rd_data;

    rom_loader u_loader (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_bank(prog_bank), .prog_we(prog_we)
    );

    slot_arbiter u_arbiter (
        .VB(VB), .rst_n(rst_n), .downloading(downloading), .busy(busy),
        .rom_cs(rom_cs), .rom_addr(rom_addr),
        .ram_cs(ram_cs), .ram_vram_sel(ram_vram_sel), .ram_addr(ram_addr),
        .ram_rnw(ram_rnw), .ram_din(ram_din), .ram_dsn(ram_dsn),
        .obj_cs(obj_cs), .obj_addr(obj_addr), .scr_cs(scr_cs), .scr_addr(scr_addr),
        .snd_cs(snd_cs), .snd_addr(snd_addr),
        .cmd_valid(cmd_valid), .cmd_slot(cmd_slot), .cmd_addr(cmd_addr),
        .cmd_bank(cmd_bank), .cmd_rnw(cmd_rnw), .cmd_wrmask(cmd_wrmask),
        .cmd_data(cmd_data), .cmd_byte_hi(cmd_byte_hi), .refresh_en(refresh_en)
    );

    sdram_request u_request (
        .VB(VB), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_slot(cmd_slot),
        .cmd_addr(cmd_addr), .cmd_bank(cmd_bank), .cmd_rnw(cmd_rnw),
        .cmd_wrmask(cmd_wrmask), .cmd_data(cmd_data), .cmd_byte_hi(cmd_byte_hi),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .busy(busy), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .sdram_bank(sdram_bank), .sdram_rnw(sdram_rnw), .sdram_wrmask(sdram_wrmask),
        .data_write(data_write), .slot_ok(slot_ok), .rd_data(rd_data),
        .snd_data(snd_data)
    );

    // One-hot ok back to each client
    assign obj_ok = slot_ok[SLOT_OBJ];
    assign scr_ok = slot_ok[SLOT_SCR];
    assign rom_ok = slot_ok[SLOT_ROM];
    assign ram_ok = slot_ok[SLOT_RAM];
    assign snd_ok = slot_ok[SLOT_SND];

    // 16-bit clients take the low half
    assign rom_data = rd_data[15:0];
    assign ram_data = rd_data[15:0];
    assign obj_data = rd_data;
    assign scr_data = rd_data;

endmodule

//--- test/cps_sdram_assertions.sv
// Protocol assertions, bound to cps_sdram_top at elaboration
`timescale 1ns/100ps

module cps_sdram_assertions import slot_pkg::*; (
    input logic      VB,
    input logic      rst_n,
    input logic      downloading,
    input logic      prog_we,
    input logic      sdram_ack,
    input logic      sdram_req,
    input slot_vec_t slot_ok
);

    // Loader write stays up until the controller takes it
    prog_we_hold: assert property (@(posedge VB) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we)
        else $error("prog_we dropped before sdram_ack");

    ok_onehot: assert property (@(posedge VB) disable iff (!rst_n) $onehot0(slot_ok))
        else $error("more than one slot ok in the same cycle");

    // Client accesses never start during a download
    no_req_in_download: assert property (@(posedge VB) disable iff (!rst_n)
        $rose(sdram_req) |-> !downloading)
        else $error("sdram_req raised while downloading");

endmodule

bind cps_sdram_top cps_sdram_assertions u_assertions (
    .VB(VB),
    .rst_n(rst_n),
    .downloading(downloading),
    .prog_we(prog_we),
    .sdram_ack(sdram_ack),
    .sdram_req(sdram_req),
    .slot_ok(slot_ok)
);

//--- test/cps_sdram_tb.sv
// Directed testbench that runs cps_sdram_top against an SDRAM model as the simulation top
`timescale 1ns/100ps

module cps_sdram_tb import sdram_map_pkg::*, slot_pkg::*; ();

    localparam int MIX_COUNT    = 12;
    localparam int ACCESS_COUNT = 6 + 1 + 6 + 2 + SLOT_COUNT + MIX_COUNT;
    // Worst access is about 14 cycles from cs to ok
    localparam int CYCLE_LIMIT  = 8 + ACCESS_COUNT * 16 + 100;

    logic        VB = 1'b0;
    logic        rst_n, downloading, ioctl_wr, prog_we, refresh_en;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_data, prog_data, snd_data;
    sdram_addr_t prog_addr, sdram_addr;
    wrmask_t     prog_mask, ram_dsn, sdram_wrmask;
    bank_t       prog_bank, sdram_bank;
    logic        rom_cs, ram_cs, obj_cs, scr_cs, snd_cs, ram_vram_sel, ram_rnw;
    logic        rom_ok, ram_ok, obj_ok, scr_ok, snd_ok;
    rom_addr_t   rom_addr;
    ram_addr_t   ram_addr;
    gfx_addr_t   obj_addr, scr_addr;
    snd_addr_t   snd_addr;
    word_t       ram_din, rom_data, ram_data, data_write;
    dword_t      obj_data, scr_data;
    logic        sdram_req, sdram_rnw;
    logic        sdram_ack = 1'b0;
    logic        data_rdy = 1'b0;
    dword_t      data_read = '0;

    slot_vec_t   cs_vec, ok_vec;
    logic [20:0] slot_addr [SLOT_COUNT];
    logic [31:0] model_lfsr = 32'hd444;
    logic [31:0] stim_lfsr = 32'hd444;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    // Client wiring by slot_id_t bit index
    assign obj_cs   = cs_vec[SLOT_OBJ];
    assign scr_cs   = cs_vec[SLOT_SCR];
    assign rom_cs   = cs_vec[SLOT_ROM];
    assign ram_cs   = cs_vec[SLOT_RAM];
    assign snd_cs   = cs_vec[SLOT_SND];
    assign obj_addr = slot_addr[SLOT_OBJ];
    assign scr_addr = slot_addr[SLOT_SCR];
    assign rom_addr = slot_addr[SLOT_ROM];
    assign ram_addr = slot_addr[SLOT_RAM][16:0];
    assign snd_addr = slot_addr[SLOT_SND][15:0];
    assign ok_vec   = {snd_ok, ram_ok, rom_ok, scr_ok, obj_ok};

    cps_sdram_top cps_sdram_top_i (.*);

    always #10 VB = ~VB;

    always @(posedge VB) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_draw(inout logic [31:0] state, input int bits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < bits; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            val   = {val[30:0], fb};
        end
        return val;
    endfunction

    // SDRAM model acks after 2 to 5 cycles and pulses data_rdy 1 to 4 cycles later
    always begin : sdram_model
        int   ack_dly;
        int   rdy_dly;
        logic is_prog;
        @(posedge VB);
        #1;
        if (rst_n && (sdram_req || prog_we)) begin
            is_prog = prog_we;
            ack_dly = 2 + int'(lfsr_draw(model_lfsr, 2));
            repeat (ack_dly - 1) @(posedge VB);
            #2;
            sdram_ack = 1'b1;
            @(posedge VB);
            #2;
            sdram_ack = 1'b0;
            // Loader writes end at the ack
            if (!is_prog) begin
                rdy_dly = int'(lfsr_draw(model_lfsr, 2));
                repeat (rdy_dly) @(posedge VB);
                #2;
                data_read = {sdram_addr[15:0], sdram_addr[15:0]};
                data_rdy  = 1'b1;
                @(posedge VB);
                #2;
                data_rdy = 1'b0;
            end
        end
    end

    task automatic compare_value(input string what, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask
    task automatic check_word(input string what, input word_t got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask
    task automatic check_dword(input string what, input dword_t got, exp);
        compare_value(what, got, exp);
    endtask
    task automatic check_byte(input string what, input byte_t got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask
    task automatic check_addr(input string what, input sdram_addr_t got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask
    task automatic check_bank(input string what, input bank_t got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask
    task automatic check_mask(input string what, input wrmask_t got, exp);
        compare_value(what, 32'(got), 32'(exp));
    endtask

    task automatic test_done(input string name, input int err0);
        tests++;
        $display("%-16s %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    // Expected SDRAM word address of a client access
    function automatic sdram_addr_t exp_addr(input slot_id_t slot, input logic [20:0] a,
                                             input logic vram);
        case (slot)
            SLOT_OBJ, SLOT_SCR: return GFX_OFFSET + {a, 1'b0};
            SLOT_ROM: return CPU_OFFSET + {1'b0, a};
            SLOT_RAM: return (vram ? VRAM_OFFSET : RAM_OFFSET) + {5'd0, a[16:0]};
            default: return SOUND_OFFSET + {7'd0, a[15:1]};
        endcase
    endfunction

    function automatic bank_t exp_bank(input slot_id_t slot);
        case (slot)
            SLOT_OBJ, SLOT_SCR: return BANK_GFX;
            SLOT_ROM: return BANK_CPU;
            default: return BANK_SND;
        endcase
    endfunction

    // Model data is the word address in both halves, valid in the ok cycle
    task automatic check_read(input slot_id_t slot, input logic [20:0] a, input logic vram);
        sdram_addr_t w;
        w = exp_addr(slot, a, vram);
        check_addr("sdram_addr", sdram_addr, w);
        check_bank("sdram_bank", sdram_bank, exp_bank(slot));
        check_bit("sdram_rnw", sdram_rnw, 1'b1);
        check_mask("sdram_wrmask", sdram_wrmask, (slot == SLOT_RAM) ? ram_dsn : 2'b11);
        case (slot)
            SLOT_OBJ: check_dword("obj_data", obj_data, {w[15:0], w[15:0]});
            SLOT_SCR: check_dword("scr_data", scr_data, {w[15:0], w[15:0]});
            SLOT_ROM: check_word("rom_data", rom_data, w[15:0]);
            SLOT_RAM: check_word("ram_data", ram_data, w[15:0]);
            default: check_byte("snd_data", snd_data, a[0] ? w[15:8] : w[7:0]);
        endcase
    endtask

    task automatic wait_ok(input slot_id_t slot);
        do begin
            @(posedge VB);
            #1;
        end while (!ok_vec[slot]);
    endtask

    task automatic issue_and_wait(input slot_id_t slot, input logic [20:0] a, input logic vram);
        @(posedge VB);
        #2;
        check_bit("refresh_en when idle", refresh_en, 1'b1);
        slot_addr[slot] = a;
        ram_vram_sel    = vram;
        cs_vec[slot]    = 1'b1;
        wait_ok(slot);
    endtask

    task automatic read_one(input slot_id_t slot, input logic [20:0] a, input logic vram);
        issue_and_wait(slot, a, vram);
        check_read(slot, a, vram);
        #1;
        cs_vec[slot] = 1'b0;
        #1;
        // Access still counts as in flight during the ok cycle
        check_bit("refresh_en while busy", refresh_en, 1'b0);
    endtask

    task automatic download_byte(input ioctl_addr_t a, input byte_t d);
        sdram_addr_t waddr;
        bank_t       bank;
        if (a < LOAD_SND_START) begin
            bank  = BANK_CPU;
            waddr = CPU_OFFSET + 22'(a >> 1);
        end else if (a < LOAD_GFX_START) begin
            bank  = BANK_SND;
            waddr = SOUND_OFFSET + 22'((a - LOAD_SND_START) >> 1);
        end else begin
            bank  = BANK_GFX;
            waddr = GFX_OFFSET + 22'((a - LOAD_GFX_START) >> 1);
        end
        @(posedge VB);
        #2;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(posedge VB);
        #2;
        ioctl_wr = 1'b0;
        check_bit("prog_we", prog_we, 1'b1);
        check_addr("prog_addr", prog_addr, waddr);
        check_bank("prog_bank", prog_bank, bank);
        check_mask("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
        check_byte("prog_data", prog_data, d);
        do begin
            @(posedge VB);
            #1;
        end while (prog_we);
        check_bit("sdram_ack at prog_we fall", sdram_ack, 1'b1);
    endtask

    task automatic download_test();
        int err0;
        err0 = errors;
        downloading = 1'b1;
        #1;
        check_bit("refresh_en in download", refresh_en, 1'b0);
        // A client that waits through the download is served only afterwards
        @(posedge VB);
        #2;
        slot_addr[SLOT_ROM] = 21'h0_0777;
        cs_vec[SLOT_ROM]    = 1'b1;
        download_byte(25'h000_0124, 8'h3c);
        download_byte(25'h001_2345, 8'ha7);
        download_byte(25'h040_0010, 8'h51);
        download_byte(25'h040_abcd, 8'he2);
        download_byte(25'h041_0000, 8'h96);
        download_byte(25'h123_4567, 8'h0f);
        check_bit("sdram_req in download", sdram_req, 1'b0);
        check_bit("rom_ok in download", rom_ok, 1'b0);
        @(posedge VB);
        #2;
        downloading = 1'b0;
        wait_ok(SLOT_ROM);
        check_read(SLOT_ROM, 21'h0_0777, 1'b0);
        #1;
        cs_vec[SLOT_ROM] = 1'b0;
        test_done("download", err0);
    endtask

    task automatic write_test();
        int   err0;
        logic vram;
        err0 = errors;
        for (int v = 0; v < 2; v++) begin
            vram    = v[0];
            ram_rnw = 1'b0;
            ram_din = vram ? 16'hbeef : 16'h1234;
            ram_dsn = vram ? 2'b01 : 2'b00;
            issue_and_wait(SLOT_RAM, 21'h0_abcd + 21'(v), vram);
            check_bit("sdram_rnw", sdram_rnw, 1'b0);
            check_mask("sdram_wrmask", sdram_wrmask, ram_dsn);
            check_word("data_write", data_write, ram_din);
            check_addr("sdram_addr", sdram_addr, exp_addr(SLOT_RAM, 21'h0_abcd + 21'(v), vram));
            check_bank("sdram_bank", sdram_bank, exp_bank(SLOT_RAM));
            #1;
            cs_vec[SLOT_RAM] = 1'b0;
            ram_rnw = 1'b1;
        end
        test_done("ram writes", err0);
    endtask

    // All five clients request at once and grants follow slot_id_t order
    task automatic priority_test();
        int       err0;
        slot_id_t order[$];
        err0 = errors;
        @(posedge VB);
        #2;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            slot_addr[i] = 21'h0_1000 + 21'(i * 273);
            cs_vec[i]    = 1'b1;
        end
        while (order.size() < SLOT_COUNT) begin
            @(posedge VB);
            #1;
            for (int i = 0; i < SLOT_COUNT; i++) begin
                if (ok_vec[i]) begin
                    order.push_back(slot_id_t'(i));
                    check_read(slot_id_t'(i), slot_addr[i], ram_vram_sel);
                end
            end
            #1;
            cs_vec = cs_vec & ~ok_vec;
        end
        for (int i = 0; i < SLOT_COUNT; i++) begin
            compare_value("grant order", 32'(order[i]), 32'(i));
        end
        test_done("priority", err0);
    endtask

    task automatic mixed_test();
        int          err0;
        slot_id_t    s;
        logic [20:0] a;
        logic        vram;
        err0 = errors;
        for (int n = 0; n < MIX_COUNT; n++) begin
            s    = slot_id_t'(lfsr_draw(stim_lfsr, 3) % 5);
            a    = 21'(lfsr_draw(stim_lfsr, 21));
            vram = lfsr_draw(stim_lfsr, 1) != 0;
            read_one(s, a, vram);
        end
        test_done("mixed traffic", err0);
    endtask

    initial begin
        int err0;
        rst_n        = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        cs_vec       = '0;
        ram_vram_sel = 1'b0;
        ram_rnw      = 1'b1;
        ram_din      = '0;
        ram_dsn      = 2'b11;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            slot_addr[i] = '0;
        end
        repeat (8) @(posedge VB);
        #2;
        rst_n = 1'b1;

        err0 = errors;
        check_bit("sdram_req", sdram_req, 1'b0);
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("any ok", |ok_vec, 1'b0);
        check_bit("refresh_en", refresh_en, 1'b1);
        test_done("reset", err0);

        download_test();
        err0 = errors;
        read_one(SLOT_OBJ, 21'h1_2345, 1'b0);
        read_one(SLOT_SCR, 21'h0_abcd, 1'b0);
        read_one(SLOT_ROM, 21'h1_fffe, 1'b0);
        read_one(SLOT_RAM, 21'h0_0321, 1'b1);
        // Both byte lanes of one sound word
        read_one(SLOT_SND, 21'h0_a5a4, 1'b0);
        read_one(SLOT_SND, 21'h0_a5a5, 1'b0);
        test_done("single reads", err0);
        write_test();
        priority_test();
        mixed_test();

        repeat (4) @(posedge VB);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- cps_sdram.f
src/sdram_map_pkg.sv
src/slot_pkg.sv
src/rom_loader.sv
src/slot_arbiter.sv
src/sdram_request.sv
src/cps_sdram_top.sv
test/cps_sdram_assertions.sv
test/cps_sdram_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f cps_sdram.f --top-module cps_sdram_tb \
    -o cps_sdram_sim > build.log 2>&1 \
    && ./obj_dir/cps_sdram_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
